/* bench/tb_board.sv */
`timescale 1ns/1ps
`include "board_defs.svh"

module tb_board;

    // ps2 timing in system cycles
    localparam int HALF      = 40;
    localparam int FRAME_GAP = 40;
    localparam int FRAME_CYC = 22 * HALF + FRAME_GAP + 1;
    localparam int CHAR_CYC  = 10 * `UART_DIV;
    // line idle this long means the master has nothing left
    localparam int QUIET_CYC = 3 * CHAR_CYC;
    localparam int NUM_KEYS  = 38;

    // test sizes
    localparam int N_PACED = 6;
    localparam int N_NOISE = 8;
    localparam int N_BURST = 3;
    localparam int N_FLOOD = 30;

    // worst case frames and character times
    // each quiet wait counts as three characters
    localparam int N_FRAMES = 3 * N_PACED + 2 * N_NOISE + 4 + N_BURST + N_FLOOD;
    localparam int N_CHARS  = N_PACED + 2 + N_BURST + N_FLOOD + 3 * (N_PACED + 6);
    localparam int WATCHDOG_CYC = 2 * (N_FRAMES * FRAME_CYC + N_CHARS * CHAR_CYC) + 100;

    logic       CLOCK_50 = 1'b0;
    logic       reset;
    logic       ps2_clk;
    logic       ps2_dat;
    logic       uart_txd;
    logic [7:0] ledg;
    logic       ledr;

    logic [31:0] rng = 32'he50c8818;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          rx_count = 0;
    logic        collect_only = 1'b0;
    logic [7:0]  exp_q[$];
    logic [7:0]  rx_q[$];

    // set-2 make codes for a..z, 0..9, space and enter
    logic [7:0] key_codes [0:NUM_KEYS-1] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A,
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46,
        8'h29, 8'h5A
    };
    // esc, backspace, tab, f1, left shift, left ctrl
    logic [7:0] unknown_codes [0:5] = '{8'h76, 8'h66, 8'h0D, 8'h05, 8'h12, 8'h14};

    board_top u_dut (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .uart_txd (uart_txd),
        .ledg     (ledg),
        .ledr     (ledr)
    );

    always #10 CLOCK_50 = ~CLOCK_50;

    // ascii follows the order of the code table
    function automatic logic [7:0] key_ascii(input int idx);
        if (idx < 26) begin
            return 8'h61 + 8'(idx);
        end else if (idx < 36) begin
            return 8'h30 + 8'(idx - 26);
        end else if (idx == 36) begin
            return 8'h20;
        end
        return 8'h0D;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic next_rand(input int range, output int value);
        rng   = xorshift32(rng);
        value = int'(rng % range);
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic expect_true(input logic cond, input string msg);
        check_count++;
        assert (cond) else report_problem(msg);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("FAILED t=%0t %s expected=%0h received=%0h", $time, name, exp, got);
        end
    endtask

    task automatic pulse_reset();
        @(posedge CLOCK_50);
        reset <= 1'b1;
        repeat (5) @(posedge CLOCK_50);
        reset <= 1'b0;
    endtask

    // start, 8 data lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        @(posedge CLOCK_50);
        for (i = 0; i < 11; i++) begin
            // data moves while ps2 clock is high
            ps2_dat <= bits[i];
            repeat (HALF) @(posedge CLOCK_50);
            ps2_clk <= 1'b0;
            repeat (HALF) @(posedge CLOCK_50);
            ps2_clk <= 1'b1;
        end
        ps2_dat <= 1'b1;
        repeat (FRAME_GAP) @(posedge CLOCK_50);
    endtask

    task automatic press_key(input int idx);
        if (!collect_only) begin
            exp_q.push_back(key_ascii(idx));
        end
        send_frame(key_codes[idx], 1'b0);
    endtask

    task automatic wait_line_quiet();
        int quiet;
        quiet = 0;
        while (quiet < QUIET_CYC) begin
            @(posedge CLOCK_50);
            if (uart_txd === 1'b1) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic finish_test(input int num, input string name, input int err_start);
        expect_true(exp_q.size() == 0,
            $sformatf("%0d expected characters never appeared on uart_txd", exp_q.size()));
        exp_q.delete();
        test_count++;
        if (error_count == err_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, error_count - err_start);
        end
    endtask

    // serial decoder sampling each bit in its middle
    initial begin : serial_rx
        logic [7:0] ch;
        int         i;
        forever begin
            @(posedge CLOCK_50);
            if (reset === 1'b0 && uart_txd === 1'b0) begin
                repeat (`UART_DIV / 2) @(posedge CLOCK_50);
                expect_true(uart_txd === 1'b0, "uart_txd start bit too short");
                for (i = 0; i < 8; i++) begin
                    repeat (`UART_DIV) @(posedge CLOCK_50);
                    ch[i] = uart_txd;
                end
                repeat (`UART_DIV) @(posedge CLOCK_50);
                expect_true(uart_txd === 1'b1, "uart_txd stop bit missing");
                rx_count++;
                if (collect_only) begin
                    rx_q.push_back(ch);
                end else begin
                    expect_true(exp_q.size() > 0,
                        $sformatf("uart_txd sent %0h while no character was expected", ch));
                    if (exp_q.size() > 0) begin
                        check_value("uart_txd", ch, exp_q.pop_front());
                    end
                end
            end
        end
    end

    task automatic test_paced();
        int err_start;
        int i;
        int idx;
        err_start = error_count;
        for (i = 0; i < N_PACED; i++) begin
            next_rand(NUM_KEYS, idx);
            press_key(idx);
            // release is break prefix plus make code
            send_frame(8'hF0, 1'b0);
            send_frame(key_codes[idx], 1'b0);
            wait_line_quiet();
            check_value("ledg", ledg, key_ascii(idx));
            check_value("ledr", ledr, 0);
        end
        finish_test(1, "paced presses", err_start);
    endtask

    task automatic test_noise();
        int         err_start;
        int         i;
        int         kind;
        int         idx;
        int         rx_before;
        logic [7:0] saved;
        err_start = error_count;
        saved     = ledg;
        rx_before = rx_count;
        for (i = 0; i < N_NOISE; i++) begin
            next_rand(3, kind);
            next_rand(NUM_KEYS, idx);
            if (kind == 0) begin
                send_frame(8'hF0, 1'b0);
                send_frame(key_codes[idx], 1'b0);
            end else if (kind == 1) begin
                send_frame(unknown_codes[idx % 6], 1'b0);
            end else begin
                send_frame(key_codes[idx], 1'b1);
            end
        end
        wait_line_quiet();
        check_value("uart_txd character count", rx_count, rx_before);
        check_value("ledg", ledg, saved);
        finish_test(2, "releases, unknown codes, parity errors", err_start);
    endtask

    task automatic test_break_prefix();
        int         err_start;
        int         idx;
        int         rx_before;
        logic [7:0] saved;
        err_start = error_count;
        saved     = ledg;
        rx_before = rx_count;
        next_rand(NUM_KEYS, idx);
        send_frame(8'hF0, 1'b0);
        send_frame(key_codes[idx], 1'b0);
        wait_line_quiet();
        check_value("uart_txd character count", rx_count, rx_before);
        check_value("ledg", ledg, saved);
        // plain press right after still counts
        next_rand(NUM_KEYS, idx);
        press_key(idx);
        wait_line_quiet();
        check_value("ledg", ledg, key_ascii(idx));
        finish_test(3, "break prefix", err_start);
    endtask

    task automatic test_short_burst();
        int err_start;
        int i;
        int idx;
        err_start = error_count;
        for (i = 0; i < N_BURST; i++) begin
            next_rand(NUM_KEYS, idx);
            press_key(idx);
        end
        wait_line_quiet();
        check_value("ledg", ledg, key_ascii(idx));
        check_value("ledr", ledr, 0);
        finish_test(4, "short burst", err_start);
    endtask

    task automatic test_overflow();
        int         err_start;
        int         i;
        int         j;
        int         idx;
        logic       in_order;
        logic [7:0] pressed[$];
        err_start = error_count;
        rx_q.delete();
        collect_only = 1'b1;
        for (i = 0; i < N_FLOOD; i++) begin
            next_rand(NUM_KEYS, idx);
            pressed.push_back(key_ascii(idx));
            press_key(idx);
        end
        wait_line_quiet();
        collect_only = 1'b0;
        check_value("ledr", ledr, 1);
        // greedy walk through the presses
        j = 0;
        in_order = 1'b1;
        foreach (rx_q[k]) begin
            while (j < pressed.size() && pressed[j] != rx_q[k]) begin
                j++;
            end
            if (j >= pressed.size()) begin
                in_order = 1'b0;
            end else begin
                j++;
            end
        end
        expect_true(in_order, "received characters are not in the order they were pressed");
        expect_true(rx_q.size() < pressed.size(), "no press was dropped on a full queue");
        expect_true(rx_q.size() > 0, "nothing was sent during the flood");
        finish_test(5, "queue overflow", err_start);
    endtask

    task automatic test_reset();
        int err_start;
        int idx;
        err_start = error_count;
        // reset lands while a character is on the line
        rx_q.delete();
        collect_only = 1'b1;
        next_rand(NUM_KEYS, idx);
        press_key(idx);
        // past the start bit, then on to a low data bit
        // ascii bit 7 is always low
        repeat (`UART_DIV) @(posedge CLOCK_50);
        while (uart_txd !== 1'b0) begin
            @(posedge CLOCK_50);
        end
        pulse_reset();
        @(posedge CLOCK_50);
        check_value("uart_txd", uart_txd, 1);
        check_value("ledg", ledg, 0);
        check_value("ledr", ledr, 0);
        // cut character is not compared
        wait_line_quiet();
        collect_only = 1'b0;
        rx_q.delete();
        finish_test(6, "reset state", err_start);
    endtask

    initial begin : main
        reset   = 1'b1;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        pulse_reset();
        test_paced();
        test_noise();
        test_break_prefix();
        test_short_burst();
        test_overflow();
        test_reset();
        $display("tests=%0d checks=%0d errors=%0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge CLOCK_50);
        $display("timeout after %0d cycles, tests did not complete", WATCHDOG_CYC);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* hw/board_defs.svh */
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// internal register bus widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// uart register block sits where the board maps its console
`define UART_BASE 32'h8000_0000

// byte offsets of the two uart registers
`define UART_DATA_OFS 32'h0000_0000
`define UART_STAT_OFS 32'h0000_0004

// CLOCK_50 cycles per serial bit
`define UART_DIV 128

// pending characters held by the bus master
// must be a power of two
`define KEY_QUEUE_DEPTH 4

`endif

/* hw/board_top.sv */
`timescale 1ns/1ps

module board_top (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic       uart_txd,
    output logic [7:0] ledg,
    output logic       ledr
);

    logic [7:0]          scan_code;
    logic                scan_valid;
    logic                frame_error;
    ps2_pkg::key_event_t key_ev;
    logic                ev_valid;
    logic [7:0]          last_char;
    logic                overflow;
    logic                tx_start;
    logic [7:0]          tx_byte;
    logic                tx_busy;

    // register bus between key master and uart
    bus_if u_bus ();

    ps2_receiver u_ps2 (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .scan_code   (scan_code),
        .scan_valid  (scan_valid),
        .frame_error (frame_error)
    );

    keymap_decoder u_keymap (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .scan_code  (scan_code),
        .scan_valid (scan_valid),
        .key_ev     (key_ev),
        .ev_valid   (ev_valid)
    );

    key_bus_master u_master (
        .CLOCK_50  (CLOCK_50),
        .reset     (reset),
        .key_ev    (key_ev),
        .ev_valid  (ev_valid),
        .bus       (u_bus.master),
        .last_char (last_char),
        .overflow  (overflow)
    );

    uart_regs u_regs (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .bus      (u_bus.slave),
        .tx_busy  (tx_busy),
        .tx_start (tx_start),
        .tx_byte  (tx_byte)
    );

    uart_tx u_tx (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .txd      (uart_txd)
    );

    // a bad frame never reaches the keymap or the uart
    a_error_not_decoded: assert property (@(posedge CLOCK_50) disable iff (reset)
        frame_error |=> !ev_valid);

    // leds show the last press and the queue overflow
    assign ledg = last_char;
    assign ledr = overflow;

endmodule

/* hw/bus_if.sv */
`timescale 1ns/1ps
`include "board_defs.svh"

interface bus_if;

    logic [`BUS_ADDR_W-1:0] addr;
    logic [`BUS_DATA_W-1:0] wdata;
    logic [`BUS_DATA_W-1:0] rdata;
    // single-cycle strobes, never both high
    logic                   we;
    logic                   re;

    // master issues cycles
    modport master (
        output addr, wdata, we, re,
        input  rdata
    );

    // slave answers, rdata valid the cycle after re
    modport slave (
        input  addr, wdata, we, re,
        output rdata
    );

endinterface

/* hw/bus_pkg.sv */
package bus_pkg;

    // register addressed by the current bus cycle
    typedef enum logic [1:0] {
        UART_REG_NONE   = 2'd0,
        UART_REG_DATA   = 2'd1,
        UART_REG_STATUS = 2'd2
    } uart_reg_t;

    // status word, bit 0 is busy
    // upper bus bits read as zero
    typedef struct packed {
        logic wr_overrun;
        logic busy;
    } uart_status_t;

endpackage

/* hw/key_bus_master.sv */
`timescale 1ns/1ps
`include "board_defs.svh"

module key_bus_master (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  ps2_pkg::key_event_t key_ev,
    input  logic                ev_valid,
    bus_if.master               bus,
    output logic [7:0]          last_char,
    output logic                overflow
);

    localparam int DEPTH = `KEY_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_SAMPLE,
        S_WRITE
    } state_t;

    state_t                 state;
    logic [7:0]             fifo_mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         count;
    logic                   push;
    logic                   pop;
    logic                   full;
    bus_pkg::uart_status_t  status;

    // only presses with a mapped character are sent
    assign push = ev_valid && key_ev.pressed && key_ev.ascii != ps2_pkg::ASCII_NONE;
    assign full = count == (PTR_W + 1)'(DEPTH);

    // status word sits in the low bits of rdata
    assign status = bus.rdata[$bits(bus_pkg::uart_status_t)-1:0];
    assign pop    = state == S_SAMPLE && !status.busy;

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overflow  <= 1'b0;
            last_char <= 8'h00;
        end else begin
            if (push) begin
                last_char <= key_ev.ascii;
            end
            // drop on full, flag stays until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(push && !full) - (PTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (push && !full) begin
            fifo_mem[wr_ptr] <= key_ev.ascii;
        end
    end

    // poll status, then write the head once the uart is free
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state  <= S_IDLE;
            bus.we <= 1'b0;
            bus.re <= 1'b0;
        end else begin
            bus.we <= 1'b0;
            bus.re <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (count != '0) begin
                        bus.re   <= 1'b1;
                        bus.addr <= `UART_BASE + `UART_STAT_OFS;
                        state    <= S_READ;
                    end
                end
                // re on the bus this cycle
                S_READ: state <= S_SAMPLE;
                S_SAMPLE: begin
                    if (!status.busy) begin
                        bus.we    <= 1'b1;
                        bus.addr  <= `UART_BASE + `UART_DATA_OFS;
                        bus.wdata <= {{(`BUS_DATA_W-8){1'b0}}, fifo_mem[rd_ptr]};
                        state     <= S_WRITE;
                    end else begin
                        // still busy, poll again
                        state <= S_IDLE;
                    end
                end
                S_WRITE: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // no write until the status answer is back
    a_no_we_during_read: assert property (@(posedge CLOCK_50) disable iff (reset)
        bus.re |-> !bus.we ##1 !bus.we);

endmodule

/* hw/keymap_decoder.sv */
`timescale 1ns/1ps

module keymap_decoder (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  logic [7:0]          scan_code,
    input  logic                scan_valid,
    output ps2_pkg::key_event_t key_ev,
    output logic                ev_valid
);

    logic break_pend;

    // set-2 make codes, lower case letters
    function automatic logic [7:0] make_to_ascii(input logic [7:0] code);
        logic [7:0] ch;
        case (code)
            8'h1C: ch = "a";  8'h32: ch = "b";  8'h21: ch = "c";  8'h23: ch = "d";
            8'h24: ch = "e";  8'h2B: ch = "f";  8'h34: ch = "g";  8'h33: ch = "h";
            8'h43: ch = "i";  8'h3B: ch = "j";  8'h42: ch = "k";  8'h4B: ch = "l";
            8'h3A: ch = "m";  8'h31: ch = "n";  8'h44: ch = "o";  8'h4D: ch = "p";
            8'h15: ch = "q";  8'h2D: ch = "r";  8'h1B: ch = "s";  8'h2C: ch = "t";
            8'h3C: ch = "u";  8'h2A: ch = "v";  8'h1D: ch = "w";  8'h22: ch = "x";
            8'h35: ch = "y";  8'h1A: ch = "z";
            8'h45: ch = "0";  8'h16: ch = "1";  8'h1E: ch = "2";  8'h26: ch = "3";
            8'h25: ch = "4";  8'h2E: ch = "5";  8'h36: ch = "6";  8'h3D: ch = "7";
            8'h3E: ch = "8";  8'h46: ch = "9";
            8'h29: ch = " ";
            // enter gives carriage return
            8'h5A: ch = 8'h0D;
            default: ch = ps2_pkg::ASCII_NONE;
        endcase
        return ch;
    endfunction

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            break_pend <= 1'b0;
            ev_valid   <= 1'b0;
        end else begin
            ev_valid <= 1'b0;
            if (scan_valid) begin
                if (scan_code == ps2_pkg::PS2_BREAK) begin
                    // prefix only, event comes with the next code
                    break_pend <= 1'b1;
                end else begin
                    break_pend <= 1'b0;
                    ev_valid   <= 1'b1;
                end
            end
        end
    end

    // event payload, qualified by ev_valid
    always_ff @(posedge CLOCK_50) begin
        if (scan_valid && scan_code != ps2_pkg::PS2_BREAK) begin
            key_ev.pressed  <= ~break_pend;
            key_ev.released <= break_pend;
            key_ev.scan     <= scan_code;
            // releases carry no character
            key_ev.ascii    <= break_pend ? ps2_pkg::ASCII_NONE : make_to_ascii(scan_code);
        end
    end

    a_press_xor_release: assert property (@(posedge CLOCK_50) disable iff (reset)
        ev_valid |-> !(key_ev.pressed && key_ev.released));

endmodule

/* hw/ps2_pkg.sv */
package ps2_pkg;

    // set-2 prefix that marks the next code as a release
    localparam logic [7:0] PS2_BREAK = 8'hF0;

    // ascii value for keys without a mapping
    localparam logic [7:0] ASCII_NONE = 8'h00;

    // one decoded key transition
    typedef struct packed {
        logic       pressed;
        logic       released;
        logic [7:0] scan;
        logic [7:0] ascii;
    } key_event_t;

endpackage

/* hw/ps2_receiver.sv */
`timescale 1ns/1ps

module ps2_receiver (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] scan_code,
    output logic       scan_valid,
    output logic       frame_error
);

    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        clk_fall;
    logic [3:0]  bit_cnt;
    logic [10:0] shreg;
    logic [10:0] frame;
    logic        frame_ok;

    // two flops per line, both idle high
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // device changes data on rising edge, so sample on falling
    assign clk_fall = clk_prev & ~clk_sync[1];

    // full frame once the current bit is appended
    // bit 0 start, 1..8 data lsb first, 9 parity, 10 stop
    assign frame = {dat_sync[1], shreg[10:1]};

    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            bit_cnt     <= 4'd0;
            scan_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            scan_valid  <= 1'b0;
            frame_error <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt <= 4'd0;
                    if (frame_ok) begin
                        scan_valid <= 1'b1;
                    end else begin
                        frame_error <= 1'b1;
                    end
                end else if (bit_cnt == 4'd0 && dat_sync[1]) begin
                    // no start bit here, wait for one
                    bit_cnt <= 4'd0;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // shift register and code carry no reset
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            shreg <= frame;
            if (bit_cnt == 4'd10) begin
                scan_code <= frame[8:1];
            end
        end
    end

    // a frame ends in exactly one outcome
    a_one_outcome: assert property (@(posedge CLOCK_50) disable iff (reset)
        !(scan_valid && frame_error));

endmodule

/* hw/uart_regs.sv */
`timescale 1ns/1ps
`include "board_defs.svh"

module uart_regs (
    input  logic       CLOCK_50,
    input  logic       reset,
    bus_if.slave       bus,
    input  logic       tx_busy,
    output logic       tx_start,
    output logic [7:0] tx_byte
);

    bus_pkg::uart_reg_t    sel;
    bus_pkg::uart_status_t status;
    logic                  overrun;

    // address decode, single slave so no external decoder
    always_comb begin
        if (bus.addr == `UART_BASE + `UART_DATA_OFS) begin
            sel = bus_pkg::UART_REG_DATA;
        end else if (bus.addr == `UART_BASE + `UART_STAT_OFS) begin
            sel = bus_pkg::UART_REG_STATUS;
        end else begin
            sel = bus_pkg::UART_REG_NONE;
        end
    end

    // busy covers the start pulse before tx_busy rises
    always_comb begin
        status            = '0;
        status.busy       = tx_busy | tx_start;
        status.wr_overrun = overrun;
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            tx_start <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (bus.we && sel == bus_pkg::UART_REG_DATA) begin
                if (status.busy) begin
                    // write dropped, remembered in status
                    overrun <= 1'b1;
                end else begin
                    tx_start <= 1'b1;
                end
            end
        end
    end

    // byte latched with the accepted write
    always_ff @(posedge CLOCK_50) begin
        if (bus.we && sel == bus_pkg::UART_REG_DATA && !status.busy) begin
            tx_byte <= bus.wdata[7:0];
        end
    end

    // read data one cycle after re, unmapped reads give zero
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            bus.rdata <= '0;
        end else if (bus.re) begin
            if (sel == bus_pkg::UART_REG_STATUS) begin
                bus.rdata <= `BUS_DATA_W'(status);
            end else begin
                bus.rdata <= '0;
            end
        end
    end

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps
`include "board_defs.svh"

module uart_tx (
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx_busy,
    output logic       txd
);

    localparam int DIV_W = $clog2(`UART_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_idx;
    logic [9:0]       frame;

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            tx_busy <= 1'b0;
            txd     <= 1'b1;
            div_cnt <= '0;
            bit_idx <= 4'd0;
        end else if (tx_start) begin
            // stop, data lsb first, start
            frame   <= {1'b1, tx_byte, 1'b0};
            txd     <= 1'b0;
            tx_busy <= 1'b1;
            div_cnt <= '0;
            bit_idx <= 4'd0;
        end else if (tx_busy) begin
            if (div_cnt == DIV_W'(`UART_DIV - 1)) begin
                div_cnt <= '0;
                if (bit_idx == 4'd9) begin
                    // stop bit done, line back to idle
                    tx_busy <= 1'b0;
                    txd     <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                    frame   <= {1'b1, frame[9:1]};
                    txd     <= frame[1];
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // register block must hold off while a character is on the line
    a_start_when_idle: assert property (@(posedge CLOCK_50) disable iff (reset)
        tx_start |-> !tx_busy);

endmodule

/* src.f */
+incdir+hw
hw/bus_pkg.sv
hw/ps2_pkg.sv
hw/bus_if.sv
hw/ps2_receiver.sv
hw/keymap_decoder.sv
hw/key_bus_master.sv
hw/uart_regs.sv
hw/uart_tx.sv
hw/board_top.sv
bench/tb_board.sv
